// ==== hdl/wdog_pkg.sv ====
// ------------------------------------------------
// Watchdog register map and reset values
// Offsets are word addresses taken from paddr[4:2]
// ------------------------------------------------
package wdog_pkg;

  // APB data width
  parameter int data_w = 32;

  // Word address width
  parameter int addr_w = 3;

  // Number of control bits
  // Bit 0 enables interrupt and counting
  // Bit 1 enables the reset output
  parameter int ctrl_w = 2;

  // ------------------------------------------------
  // Register offsets
  // ------------------------------------------------
  parameter logic [addr_w-1:0] addr_load    = addr_w'(0);
  parameter logic [addr_w-1:0] addr_value   = addr_w'(1);
  parameter logic [addr_w-1:0] addr_control = addr_w'(2);
  // Write only
  parameter logic [addr_w-1:0] addr_intclr  = addr_w'(3);
  parameter logic [addr_w-1:0] addr_ris     = addr_w'(4);
  parameter logic [addr_w-1:0] addr_mis     = addr_w'(5);

  // ------------------------------------------------
  // Reset values
  // ------------------------------------------------
  // Load register and counter come up all ones
  // so no interrupt fires soon after reset
  parameter logic [data_w-1:0] load_rst_val = '1;

endpackage

// ==== hdl/wdog_regs.sv ====
// ------------------------------------------------
// Writes land in the APB setup phase, reads are combinational
// All writes are blocked while wdog_lock is high
// ------------------------------------------------
module wdog_regs
  import wdog_pkg::*;
#(
  parameter int count_w = 32
)
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [addr_w-1:0]  paddr,
  input  logic [data_w-1:0]  pwdata,
  input  logic               wdog_lock,
  input  logic [count_w-1:0] count_read,
  input  logic               ris_read,
  input  logic               mis,
  output logic [data_w-1:0]  prdata,
  output logic [count_w-1:0] load_val,
  output logic               int_en,
  output logic               res_en,
  output logic               load_wr,
  output logic               clr_wr
);

  logic              wr_en;
  logic              ctrl_wr;
  logic [ctrl_w-1:0] ctrl_q;

  // ------------------------------------------------
  // Write decode
  // ------------------------------------------------
  // Setup phase write, masked by lock
  assign wr_en   = psel & ~penable & pwrite & ~wdog_lock;
  assign ctrl_wr = wr_en & (paddr == addr_control);
  // One cycle pulses towards the request hold logic
  assign load_wr = wr_en & (paddr == addr_load);
  assign clr_wr  = wr_en & (paddr == addr_intclr);

  // Control register
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl_q <= '0;
    end
    else if (ctrl_wr)
    begin
      ctrl_q <= pwdata[ctrl_w-1:0];
    end
  end

  assign int_en = ctrl_q[0];
  assign res_en = ctrl_q[1];

  // Load register
  // Updates on the same edge that raises load_req
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_val <= load_rst_val[count_w-1:0];
    end
    else if (load_wr)
    begin
      load_val <= pwdata[count_w-1:0];
    end
  end

  // ------------------------------------------------
  // Read multiplexer
  // ------------------------------------------------
  // Zero outside a read, on the clear address and on unmapped offsets
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        addr_load:    prdata = data_w'(load_val);
        addr_value:   prdata = data_w'(count_read);
        addr_control: prdata = data_w'(ctrl_q);
        addr_ris:     prdata = data_w'(ris_read);
        addr_mis:     prdata = data_w'(mis);
        default:      prdata = '0;
      endcase
    end
  end

  // Lock freezes both registers over the write edge
  a_lock_holds: assert property (@(posedge PCLK) disable iff (!PRESETn)
    wdog_lock |=> ($stable(ctrl_q) && $stable(load_val)));

endmodule

// ==== hdl/wdog_req_hold.sv ====
// ------------------------------------------------
// Load and clear writes are held until the next count strobe
// A clear stays active while the counter still shows zero
// ------------------------------------------------
module wdog_req_hold
(
  input  logic PCLK,
  input  logic PRESETn,
  input  logic wdog_clk_en,
  input  logic load_wr,
  input  logic clr_wr,
  input  logic count_zero,
  output logic load_req,
  output logic clr_req
);

  logic clr_pend;
  logic clr_hold;

  // ------------------------------------------------
  // Pending requests
  // ------------------------------------------------
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_req <= 1'b0;
      clr_pend <= 1'b0;
      clr_hold <= 1'b0;
    end
    else
    begin
      // Held until a strobe edge consumes it
      // A repeated load merges into the pending one
      load_req <= load_wr | (load_req & ~wdog_clk_en);
      // New clear only taken when none is active
      clr_pend <= (clr_wr & ~clr_req) | (clr_pend & ~wdog_clk_en);
      // Remember the clear across the strobe that saw it
      if (wdog_clk_en)
      begin
        clr_hold <= clr_req;
      end
    end
  end

  // Clear extension
  // After the strobe, count_zero may still be high from the old zero event.
  // Keeping the clear up until it drops stops ris from setting twice.
  assign clr_req = clr_pend | (clr_hold & count_zero);

  // Extended clear only ends once the counter has left zero
  a_clr_ext: assert property (@(posedge PCLK) disable iff (!PRESETn)
    $fell(clr_req) |-> !count_zero);

endmodule

// ==== hdl/wdog_counter.sv ====
// ------------------------------------------------
// Reloadable down-counter built from two half-width halves
// count_w must be even, counts only on wdog_clk_en
// ------------------------------------------------
module wdog_counter
  import wdog_pkg::*;
#(
  parameter int count_w = 32
)
(
  input  logic               PCLK,
  input  logic               PRESETn,
  input  logic               wdog_clk_en,
  input  logic [count_w-1:0] load_val,
  input  logic               int_en,
  input  logic               load_req,
  input  logic               clr_req,
  input  logic               wdogres,
  output logic [count_w-1:0] count_read,
  output logic               count_zero
);

  localparam int half_w = count_w / 2;

  logic               int_en_q;
  logic               int_en_rise;
  logic               stop_q;
  logic               count_stop;
  logic               count_en;
  logic               reload;
  logic [count_w-1:0] count_q;
  logic [count_w-1:0] count_nxt;
  logic [1:0]         carry_q;
  logic [half_w-1:0]  nxt_low;
  logic [half_w-1:0]  nxt_high;
  logic [half_w-1:0]  high_src;
  logic               nxt_carry_0;
  logic               nxt_carry_1;

  // ------------------------------------------------
  // Reload and enable terms
  // ------------------------------------------------
  // One strobe wide after int_en goes high
  assign int_en_rise = int_en & ~int_en_q;

  // Registered upper carry marks a zero count
  assign count_zero = carry_q[1];

  // Reload on new load, zero, fresh enable or interrupt clear
  assign reload = load_req | count_zero | int_en_rise | clr_req;

  // Stopped by the reset output, released by a load
  assign count_stop = wdogres | (~load_req & stop_q);

  // A pending load moves the counter even when disabled
  assign count_en = (int_en & ~count_stop) | load_req;

  // ------------------------------------------------
  // Split decrement
  // ------------------------------------------------
  // Low half decrements on every enabled strobe
  assign nxt_low = count_q[half_w-1:0] - 1'b1;

  // High half borrows from the registered low carry
  assign nxt_high = carry_q[0] ? (count_q[count_w-1:half_w] - 1'b1) :
                                 count_q[count_w-1:half_w];

  // Low half predicts a wrap on the next strobe
  always_comb
  begin
    if (reload)
    begin
      nxt_carry_0 = (load_val[half_w-1:0] == '0);
    end
    else
    begin
      nxt_carry_0 = (count_q[half_w-1:0] == half_w'(1));
    end
  end

  // Upper half value seen by the zero prediction
  assign high_src = reload ? load_val[count_w-1:half_w] : count_q[count_w-1:half_w];

  // Whole count reaches zero on the next strobe
  assign nxt_carry_1 = (high_src == '0) & nxt_carry_0 & ~count_zero;

  assign count_nxt = reload ? load_val : {nxt_high, nxt_low};

  // ------------------------------------------------
  // Counter registers
  // ------------------------------------------------
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      count_q  <= load_rst_val[count_w-1:0];
      carry_q  <= 2'b00;
      stop_q   <= 1'b0;
      int_en_q <= 1'b0;
    end
    else if (wdog_clk_en)
    begin
      int_en_q <= int_en;
      stop_q   <= count_stop;
      // Carries move only with the count
      if (count_en)
      begin
        count_q <= count_nxt;
        carry_q <= {nxt_carry_1, nxt_carry_0};
      end
    end
  end

  // Freshly written load value reads back before the strobe takes it
  assign count_read = load_req ? load_val : count_q;

  // Stopped count holds until a load arrives
  a_stop_holds: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (count_stop && !load_req) |=> $stable(count_q));

endmodule

// ==== hdl/wdog_irq_res.sv ====
// ------------------------------------------------
// Interrupt status and watchdog reset, updated per strobe
// wdogres holds until res_en is cleared
// ------------------------------------------------
module wdog_irq_res
(
  input  logic PCLK,
  input  logic PRESETn,
  input  logic wdog_clk_en,
  input  logic count_zero,
  input  logic clr_req,
  input  logic int_en,
  input  logic res_en,
  output logic ris_read,
  output logic mis,
  output logic wdogint,
  output logic wdogres
);

  logic ris;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ris     <= 1'b0;
      wdogres <= 1'b0;
    end
    else if (wdog_clk_en)
    begin
      // Set on zero, held until a clear
      ris <= (count_zero | ris) & ~clr_req;
      // Second zero while still unserviced
      if (!res_en)
      begin
        wdogres <= 1'b0;
      end
      else if (ris && count_zero)
      begin
        wdogres <= 1'b1;
      end
    end
  end

  // Pending clear already hides the status in read-back
  assign ris_read = ris & ~clr_req;
  assign mis      = ris_read & int_en;
  assign wdogint  = mis;

  // Reset only follows an interrupt left standing
  a_res_after_ris: assert property (@(posedge PCLK) disable iff (!PRESETn)
    $rose(wdogres) |-> $past(ris));

endmodule

// ==== hdl/wdog_frc.sv ====
// ------------------------------------------------
// Single clock watchdog on PCLK with wdog_clk_en as count strobe
// count_w must be even and no wider than data_w
// ------------------------------------------------
module wdog_frc
  import wdog_pkg::*;
#(
  parameter int count_w = 32
)
(
  input  logic              PCLK,
  input  logic              PRESETn,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [addr_w-1:0] paddr,
  input  logic [data_w-1:0] pwdata,
  input  logic              wdog_lock,
  input  logic              wdog_clk_en,
  output logic [data_w-1:0] prdata,
  output logic              wdogint,
  output logic              wdogres
);

  logic [count_w-1:0] load_val;
  logic [count_w-1:0] count_read;
  logic               int_en;
  logic               res_en;
  logic               load_wr;
  logic               clr_wr;
  logic               load_req;
  logic               clr_req;
  logic               count_zero;
  logic               ris_read;
  logic               mis;

  // ------------------------------------------------
  // Register port
  // ------------------------------------------------
  wdog_regs #(
    .count_w    (count_w)
  ) wdog_regs_i (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .wdog_lock  (wdog_lock),
    .count_read (count_read),
    .ris_read   (ris_read),
    .mis        (mis),
    .prdata     (prdata),
    .load_val   (load_val),
    .int_en     (int_en),
    .res_en     (res_en),
    .load_wr    (load_wr),
    .clr_wr     (clr_wr)
  );

  // Requests wait here for the strobe
  wdog_req_hold wdog_req_hold_i (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .wdog_clk_en (wdog_clk_en),
    .load_wr     (load_wr),
    .clr_wr      (clr_wr),
    .count_zero  (count_zero),
    .load_req    (load_req),
    .clr_req     (clr_req)
  );

  // ------------------------------------------------
  // Counter and outputs
  // ------------------------------------------------
  wdog_counter #(
    .count_w     (count_w)
  ) wdog_counter_i (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .wdog_clk_en (wdog_clk_en),
    .load_val    (load_val),
    .int_en      (int_en),
    .load_req    (load_req),
    .clr_req     (clr_req),
    .wdogres     (wdogres),
    .count_read  (count_read),
    .count_zero  (count_zero)
  );

  // wdogres also stops the counter
  wdog_irq_res wdog_irq_res_i (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .wdog_clk_en (wdog_clk_en),
    .count_zero  (count_zero),
    .clr_req     (clr_req),
    .int_en      (int_en),
    .res_en      (res_en),
    .ris_read    (ris_read),
    .mis         (mis),
    .wdogint     (wdogint),
    .wdogres     (wdogres)
  );

endmodule

// ==== bench/wdog_model.svh ====
// ------------------------------------------------
// Cycle model of the watchdog, included in the testbench
// Model assumes every load value written is nonzero
// ------------------------------------------------
`ifndef WDOG_MODEL_SVH
`define WDOG_MODEL_SVH

localparam int          clk_period = 4;
localparam logic [31:0] lfsr_seed  = 32'hbdd5_4241;
// Idle cycles allowed while waiting on an output
localparam int          wait_limit = 400;

// Model state after the last PCLK edge
logic [ctrl_w-1:0] m_ctrl;
logic [data_w-1:0] m_load;
logic [data_w-1:0] m_count;
logic              m_load_req;
logic              m_clr_pend;
logic              m_clr_hold;
logic              m_zero;
logic              m_stop;
logic              m_en_q;
logic              m_ris;
logic              m_res;
logic [31:0]       lfsr_q;

// ------------------------------------------------
// Random numbers
// ------------------------------------------------
// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken
function automatic logic rand_bit();
  rand_bit = lfsr_q[0];
  lfsr_q   = lfsr_step(lfsr_q);
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    r = {r[30:0], rand_bit()};
  end
  return r;
endfunction

// ------------------------------------------------
// Model outputs
// ------------------------------------------------
// Pending clear, or clear stretched over a zero count
function automatic logic model_clr_req();
  return m_clr_pend | (m_clr_hold & m_zero);
endfunction

function automatic logic exp_ris();
  return m_ris & ~model_clr_req();
endfunction

function automatic logic exp_mis();
  return exp_ris() & m_ctrl[0];
endfunction

function automatic logic [data_w-1:0] exp_prdata(input logic sel, input logic wr,
                                                 input logic [addr_w-1:0] addr);
  if (!sel || wr)
  begin
    return '0;
  end
  case (addr)
    addr_load:    return m_load;
    addr_value:   return m_load_req ? m_load : m_count;
    addr_control: return data_w'(m_ctrl);
    addr_ris:     return data_w'(exp_ris());
    addr_mis:     return data_w'(exp_mis());
    default:      return '0;
  endcase
endfunction

// ------------------------------------------------
// Model update
// ------------------------------------------------
task automatic model_reset();
  m_ctrl     = '0;
  m_load     = load_rst_val;
  m_count    = load_rst_val;
  m_load_req = 1'b0;
  m_clr_pend = 1'b0;
  m_clr_hold = 1'b0;
  m_zero     = 1'b0;
  m_stop     = 1'b0;
  m_en_q     = 1'b0;
  m_ris      = 1'b0;
  m_res      = 1'b0;
endtask

// Advance by one PCLK edge with the inputs present at that edge
task automatic model_step(input logic sel, input logic en, input logic wr,
                          input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                          input logic lock, input logic strobe);
  logic wr_ok;
  logic clr_req;
  logic int_en;
  logic reload;
  logic stop_now;
  logic nxt_load_req;
  logic nxt_clr_pend;
  wr_ok        = sel & ~en & wr & ~lock;
  clr_req      = model_clr_req();
  int_en       = m_ctrl[0];
  nxt_load_req = (wr_ok & (addr == addr_load)) | (m_load_req & ~strobe);
  nxt_clr_pend = (wr_ok & (addr == addr_intclr) & ~clr_req) | (m_clr_pend & ~strobe);
  if (strobe)
  begin
    // All terms taken from before this strobe
    reload   = m_load_req | m_zero | (int_en & ~m_en_q) | clr_req;
    stop_now = m_res | (~m_load_req & m_stop);
    if (!m_ctrl[1])
    begin
      m_res = 1'b0;
    end
    else if (m_ris && m_zero)
    begin
      m_res = 1'b1;
    end
    m_ris = (m_zero | m_ris) & ~clr_req;
    // Pending load moves the count even while disabled or stopped
    if ((int_en && !stop_now) || m_load_req)
    begin
      m_count = reload ? m_load : m_count - 1'b1;
      m_zero  = (m_count == '0);
    end
    m_en_q     = int_en;
    m_stop     = stop_now;
    m_clr_hold = clr_req;
  end
  if (wr_ok && addr == addr_control)
  begin
    m_ctrl = wdata[ctrl_w-1:0];
  end
  if (wr_ok && addr == addr_load)
  begin
    m_load = wdata;
  end
  m_load_req = nxt_load_req;
  m_clr_pend = nxt_clr_pend;
endtask

// ------------------------------------------------
// Compare tasks
// ------------------------------------------------
task automatic check_word(input string name, input logic [data_w-1:0] got,
                          input logic [data_w-1:0] exp);
  if (got !== exp)
  begin
    $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    stop_with_failure();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    stop_with_failure();
  end
endtask

`endif

// ==== bench/wdog_frc_tb.sv ====
// ------------------------------------------------
// Random strobes and APB traffic, checked every cycle
// Loads are kept small and nonzero
// ------------------------------------------------
module wdog_frc_tb
  import wdog_pkg::*;
();

  logic              PCLK;
  logic              PRESETn;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic              wdog_lock;
  logic              wdog_clk_en;
  logic [data_w-1:0] prdata;
  logic              wdogint;
  logic              wdogres;
  logic              lock_level;

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  `include "wdog_model.svh"

  wdog_frc #(
    .count_w     (data_w)
  ) wdog_frc_i (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .wdog_lock   (wdog_lock),
    .wdog_clk_en (wdog_clk_en),
    .prdata      (prdata),
    .wdogint     (wdogint),
    .wdogres     (wdogres)
  );

  initial
  begin
    PCLK = 1'b0;
    forever #(clk_period / 2) PCLK = ~PCLK;
  end

  // ------------------------------------------------
  // Bus driver
  // ------------------------------------------------
  // Drive on the falling edge, check mid low phase, then step the model
  task automatic drive_cycle(input logic sel, input logic en, input logic wr,
                             input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
    @(negedge PCLK);
    psel        = sel;
    penable     = en;
    pwrite      = wr;
    paddr       = addr;
    pwdata      = wdata;
    wdog_lock   = lock_level;
    wdog_clk_en = rand_bit();
    #1;
    check_word("prdata", prdata, exp_prdata(sel, wr, addr));
    check_bit("wdogint", wdogint, exp_mis());
    check_bit("wdogres", wdogres, m_res);
    model_step(sel, en, wr, addr, wdata, lock_level, wdog_clk_en);
  endtask

  // Idle bus cycle still reads a random offset
  task automatic idle_cycle();
    drive_cycle(1'b1, 1'b0, 1'b0, addr_w'(rand_bits(3)), '0);
  endtask

  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
    drive_cycle(1'b1, 1'b0, 1'b1, addr, wdata);
    drive_cycle(1'b1, 1'b1, 1'b1, addr, wdata);
    drive_cycle(1'b0, 1'b0, 1'b0, addr, '0);
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr);
    drive_cycle(1'b1, 1'b0, 1'b0, addr, '0);
    drive_cycle(1'b1, 1'b1, 1'b0, addr, '0);
  endtask

  // Polls wdogint, or wdogres when pick_res is set
  task automatic wait_for_level(input logic pick_res, input logic level);
    int n;
    n = 0;
    while ((pick_res ? wdogres : wdogint) !== level)
    begin
      if (n == wait_limit)
      begin
        $display("Timed out waiting for %s to become %0d",
                 pick_res ? "wdogres" : "wdogint", level);
        stop_with_failure();
      end
      idle_cycle();
      n++;
    end
  endtask

  function automatic logic [data_w-1:0] small_load();
    return data_w'(rand_bits(3)) + 1'b1;
  endfunction

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial
  begin
    int op;
    PRESETn     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    wdog_lock   = 1'b0;
    wdog_clk_en = 1'b0;
    lock_level  = 1'b0;
    lfsr_q      = lfsr_seed;
    model_reset();
    repeat (10) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;

    // Reset values on every offset
    for (int a = 0; a < 8; a++)
    begin
      apb_read(addr_w'(a));
    end

    // First interrupt after a small load
    apb_write(addr_load, small_load());
    apb_read(addr_value);
    apb_write(addr_control, data_w'(1));
    wait_for_level(1'b0, 1'b1);

    // Clear drops status at once, interrupt comes back
    apb_write(addr_intclr, rand_bits(32));
    apb_read(addr_ris);
    apb_read(addr_mis);
    wait_for_level(1'b0, 1'b1);

    // Unserviced second zero fires the reset and stops the count
    apb_write(addr_control, data_w'(3));
    wait_for_level(1'b1, 1'b1);
    repeat (8) apb_read(addr_value);
    apb_write(addr_load, small_load());
    repeat (8) idle_cycle();
    apb_write(addr_control, data_w'(1));
    wait_for_level(1'b1, 1'b0);
    apb_write(addr_intclr, '0);
    apb_write(addr_load, small_load());
    wait_for_level(1'b0, 1'b1);

    // Locked writes go nowhere
    lock_level = 1'b1;
    repeat (12)
    begin
      apb_write(addr_w'(rand_bits(3)), rand_bits(32));
    end
    // Every register still reads its old value
    for (int a = 0; a < 8; a++)
    begin
      apb_read(addr_w'(a));
    end
    lock_level = 1'b0;

    // Masked status follows int_en, re-enable reloads
    apb_write(addr_control, '0);
    apb_read(addr_ris);
    apb_read(addr_mis);
    repeat (4) idle_cycle();
    apb_write(addr_control, data_w'(1));
    apb_write(addr_intclr, '0);
    wait_for_level(1'b0, 1'b1);

    // Mixed random traffic
    repeat (80)
    begin
      op = int'(rand_bits(2));
      case (op)
        0: idle_cycle();
        1: apb_write(addr_load, small_load());
        2: apb_write(addr_control, rand_bits(2));
        default: apb_write(addr_intclr, rand_bits(32));
      endcase
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+bench
hdl/wdog_pkg.sv
hdl/wdog_regs.sv
hdl/wdog_req_hold.sv
hdl/wdog_counter.sv
hdl/wdog_irq_res.sv
hdl/wdog_frc.sv
bench/wdog_frc_tb.sv

// ==== Bender.yml ====
package:
  name: wdog_frc

sources:
  - hdl/wdog_pkg.sv
  - hdl/wdog_regs.sv
  - hdl/wdog_req_hold.sv
  - hdl/wdog_counter.sv
  - hdl/wdog_irq_res.sv
  - hdl/wdog_frc.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/wdog_frc_tb.sv
